// File: sound_pkg.sv
`default_nettype none

package sound_pkg;

    localparam int PERIOD_W  = 19;
    localparam int STAGE_W   = 5;
    localparam int FRAC_W    = 8;
    localparam int WB_ADDR_W = 4;
    localparam int WB_DATA_W = 32;

    typedef logic [PERIOD_W-1:0]  period_t;   // Tone period in clock cycles
    typedef logic [STAGE_W-1:0]   stage_t;
    typedef logic [FRAC_W-1:0]    frac_t;     // Duty share in 1/256 of a period
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        PLAY = 2'b01,
        DONE = 2'b10
    } player_state_t;

    localparam int      NUM_STAGES   = 31;
    localparam stage_t  LAST_STAGE   = 5'd30;
    localparam period_t PERIOD_RESET = 19'd166666;  // 300 Hz at 50 MHz

    // Register map, byte addresses
    localparam wb_addr_t ADDR_CTRL    = 4'h0;
    localparam wb_addr_t ADDR_PERIOD  = 4'h4;
    localparam wb_addr_t ADDR_TRIGGER = 4'h8;
    localparam wb_addr_t ADDR_STATUS  = 4'hC;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_SEL_BIT    = 1;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_STAGE_LO = 8;

    // Jump curve, decay counts rescaled to 1/256 of the period
    localparam frac_t JUMP_ENV [0:NUM_STAGES-1] = '{
        8'd128, 8'd108, 8'd91,  8'd77,
        8'd65,  8'd55,  8'd46,  8'd39,
        8'd33,  8'd28,  8'd23,  8'd20,
        8'd17,  8'd14,  8'd12,  8'd10,
        8'd8,   8'd7,   8'd6,   8'd5,
        8'd4,   8'd4,   8'd3,   8'd3,
        8'd2,   8'd2,   8'd2,   8'd1,
        8'd1,   8'd0,   8'd0
    };

    // Land thud, louder start and coarse steps
    localparam frac_t LAND_ENV [0:NUM_STAGES-1] = '{
        8'd200, 8'd200, 8'd200,
        8'd160, 8'd160, 8'd160,
        8'd128, 8'd128, 8'd128,
        8'd96,  8'd96,  8'd96,
        8'd64,  8'd64,  8'd64,
        8'd48,  8'd48,  8'd48,
        8'd32,  8'd32,  8'd32,
        8'd24,  8'd24,
        8'd16,  8'd16,
        8'd12,
        8'd8,   8'd8,
        8'd4,   8'd4,
        8'd0
    };

endpackage

`default_nettype wire

// File: voice_ctrl_if.sv
`default_nettype none

interface voice_ctrl_if;
    import sound_pkg::*;

    logic    enable;
    logic    sound_sel;   // 0 jump, 1 land
    period_t period;
    logic    trigger;     // Single cycle start pulse
    logic    busy;
    stage_t  stage;

    modport regs (
        output enable, sound_sel, period, trigger,
        input  busy, stage
    );

    modport player (
        input  enable, sound_sel, period, trigger,
        output busy, stage
    );

endinterface

`default_nettype wire

// File: sound_regs.sv
`default_nettype none

module sound_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  sound_pkg::wb_addr_t wb_adr,
    input  sound_pkg::wb_data_t wb_dat_w,
    output sound_pkg::wb_data_t wb_dat_r,
    output logic                wb_ack,
    voice_ctrl_if.regs          ctrl
);
    import sound_pkg::*;

    logic     enable_q;
    logic     sel_q;
    period_t  period_q;
    logic     trigger_q;
    logic     access;
    logic     wr_en;
    wb_data_t status_word;
    wb_data_t rd_data;

    // New cycle seen, the guard keeps ack to one cycle
    assign access = wb_cyc && wb_stb && !wb_ack;
    assign wr_en  = access && wb_we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
            sel_q    <= 1'b0;
            period_q <= PERIOD_RESET;
        end else if (wr_en) begin
            case (wb_adr)
                ADDR_CTRL: begin
                    enable_q <= wb_dat_w[CTRL_ENABLE_BIT];
                    sel_q    <= wb_dat_w[CTRL_SEL_BIT];
                end
                ADDR_PERIOD: begin
                    period_q <= wb_dat_w[PERIOD_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Pulse lines up with ack of the TRIGGER write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trigger_q <= 1'b0;
        end else begin
            trigger_q <= wr_en && (wb_adr == ADDR_TRIGGER) && enable_q;
        end
    end

    always_comb begin
        status_word = '0;
        status_word[STATUS_BUSY_BIT] = ctrl.busy;
        status_word[STATUS_STAGE_LO +: STAGE_W] = ctrl.stage;
    end

    always_comb begin
        rd_data = '0;  // Unmapped and TRIGGER read as zero
        case (wb_adr)
            ADDR_CTRL: begin
                rd_data[CTRL_ENABLE_BIT] = enable_q;
                rd_data[CTRL_SEL_BIT]    = sel_q;
            end
            ADDR_PERIOD: begin
                rd_data[PERIOD_W-1:0] = period_q;
            end
            ADDR_STATUS: begin
                rd_data = status_word;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    // Read data valid together with ack
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= wb_we ? '0 : rd_data;
        end
    end

    assign ctrl.enable    = enable_q;
    assign ctrl.sound_sel = sel_q;
    assign ctrl.period    = period_q;
    assign ctrl.trigger   = trigger_q;

endmodule

`default_nettype wire

// File: sound_player.sv
`default_nettype none

module sound_player (
    input  logic         clk,
    input  logic         rst_n,
    voice_ctrl_if.player ctrl,
    output logic         wave_out
);
    import sound_pkg::*;

    player_state_t               state;
    period_t                     counter;
    period_t                     counter_inc;
    period_t                     period_q;
    period_t                     threshold;
    period_t                     thr_load;
    stage_t                      stage;
    stage_t                      stage_load;
    frac_t                       frac_load;
    logic [PERIOD_W+FRAC_W-1:0]  product;
    logic                        start;
    logic                        stage_end;
    logic                        last_stage;
    logic                        load;

    assign start       = ctrl.trigger && ctrl.enable;
    assign counter_inc = counter + 1'b1;
    assign stage_end   = (counter == period_q - 1'b1);
    assign last_stage  = (stage == LAST_STAGE);

    // Stage entered at the next boundary, or stage 0 on a (re)start
    assign stage_load = (start || last_stage) ? '0 : stage + 1'b1;
    assign frac_load  = ctrl.sound_sel ? LAND_ENV[stage_load] : JUMP_ENV[stage_load];

    // High time of the coming stage, period * frac / 256
    assign product  = ctrl.period * frac_load;
    assign thr_load = product[PERIOD_W+FRAC_W-1:FRAC_W];

    assign load = start || ((state == PLAY) && stage_end && !last_stage);

    // Period and shape only change at a stage boundary
    always_ff @(posedge clk) begin
        if (load) begin
            period_q  <= ctrl.period;
            threshold <= thr_load;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            stage    <= '0;
            counter  <= '0;
            wave_out <= 1'b0;
        end else if (!ctrl.enable) begin
            state    <= IDLE;  // Disable wins over everything
            stage    <= '0;
            counter  <= '0;
            wave_out <= 1'b0;
        end else if (start) begin
            state    <= PLAY;
            stage    <= '0;
            counter  <= '0;
            wave_out <= (thr_load != '0);
        end else begin
            case (state)
                PLAY: begin
                    if (stage_end) begin
                        if (last_stage) begin
                            state    <= DONE;
                            wave_out <= 1'b0;
                        end else begin
                            stage    <= stage_load;
                            counter  <= '0;
                            wave_out <= (thr_load != '0);
                        end
                    end else begin
                        counter  <= counter_inc;
                        wave_out <= (counter_inc < threshold);
                    end
                end
                DONE: begin
                    state   <= IDLE;  // One cycle, busy still high
                    stage   <= '0;
                    counter <= '0;
                end
                default: begin
                    stage    <= '0;
                    counter  <= '0;
                    wave_out <= 1'b0;
                end
            endcase
        end
    end

    assign ctrl.busy  = (state != IDLE);
    assign ctrl.stage = stage;

endmodule

`default_nettype wire

// File: sound_unit_top.sv
`default_nettype none

module sound_unit_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  sound_pkg::wb_addr_t wb_adr,
    input  sound_pkg::wb_data_t wb_dat_w,
    output sound_pkg::wb_data_t wb_dat_r,
    output logic                wb_ack,
    output logic                wave_out
);

    voice_ctrl_if ctrl_if ();  // Register block to player

    sound_regs sound_regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ctrl     (ctrl_if.regs)
    );

    sound_player sound_player_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl_if.player),
        .wave_out (wave_out)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    localparam int HALF_PERIOD = 20;  // 40 time unit clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: sound_unit_tb.sv
`default_nettype none

module sound_unit_tb;
    import sound_pkg::*;

    localparam int WB_TIMEOUT      = 16;
    localparam int WATCHDOG_CYCLES = 3 * 31 * 64 * 6 + 4000;

    logic     clk;
    logic     rst_n;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;
    logic     wave_out;

    int seed = 32'h6b6e;
    int check_count = 0;
    int error_count = 0;
    int errors_at_start = 0;
    int ack_count = 0;
    int busy_run = 0;
    int last_busy_len = 0;
    int high_cnt [0:NUM_STAGES-1];

    tb_clk_gen tb_clk_gen_i (
        .clk (clk)
    );

    sound_unit_top sound_unit_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wave_out (wave_out)
    );

    always @(negedge clk) begin
        if (wb_ack) begin
            ack_count <= ack_count + 1;
        end
    end

    // Length of the last busy stretch, in cycles
    always @(negedge clk) begin
        if (sound_unit_top_i.ctrl_if.busy) begin
            busy_run <= busy_run + 1;
        end else if (busy_run != 0) begin
            last_busy_len <= busy_run;
            busy_run      <= 0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got == exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic wb_access(input logic we, input wb_addr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = addr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wb_ack && waited < WB_TIMEOUT);
        rdata = wb_dat_r;
        if (!wb_ack) begin
            $display("Wishbone access to address 0x%0h was never acknowledged", addr);
            error_count++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
        wb_data_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
        wb_access(1'b0, addr, '0, data);
    endtask

    // Windows start on the edge after the trigger ack
    task automatic measure_windows(input int period, input int count);
        @(posedge clk);
        for (int w = 0; w < count; w++) begin
            high_cnt[w] = 0;
            repeat (period) begin
                @(negedge clk);
                if (wave_out) begin
                    high_cnt[w]++;
                end
            end
        end
    endtask

    function automatic int expected_high(input int period, input int frac);
        return (period * frac) >> 8;
    endfunction

    task automatic check_windows(input int period, input logic sel, input int count);
        int frac;
        for (int w = 0; w < count; w++) begin
            frac = sel ? int'(LAND_ENV[w]) : int'(JUMP_ENV[w]);
            check_value($sformatf("wave_out high count, stage %0d", w),
                        high_cnt[w], expected_high(period, frac));
        end
    endtask

    task automatic wait_idle(output wb_data_t status);
        int polls;
        polls = 0;
        do begin
            wb_read(ADDR_STATUS, status);
            polls++;
        end while (status[0] && polls < 2000);
        if (status[0]) begin
            $display("Player stayed busy long after the sound should have ended");
            error_count++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = error_count - errors_at_start;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        wb_data_t rd;
        int       period;
        int       highs;
        int       acks;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        acks = ack_count;
        wb_read(ADDR_CTRL, rd);
        check_value("wb_dat_r CTRL", rd, 0);
        wb_read(ADDR_PERIOD, rd);
        check_value("wb_dat_r PERIOD", rd, 166666);
        wb_read(ADDR_STATUS, rd);
        check_value("wb_dat_r STATUS", rd, 0);
        repeat (2) @(negedge clk);
        check_value("wb_ack cycles", ack_count - acks, 3);  // One per access
        end_test(1, "reset values");

        wb_write(ADDR_CTRL, 32'h1);
        wb_write(ADDR_PERIOD, 32'd64);
        wb_write(ADDR_TRIGGER, 32'h1);
        fork
            measure_windows(64, NUM_STAGES);
            begin
                repeat (64 * 15) @(posedge clk);
                wb_read(ADDR_STATUS, rd);
                check_value("STATUS busy mid-sound", rd[0], 1);
                check_value("STATUS stage mid-sound", rd[12:8], 15);
            end
        join
        check_windows(64, 1'b0, NUM_STAGES);
        @(posedge clk);  // Read samples the first cycle after DONE
        wb_read(ADDR_STATUS, rd);
        check_value("STATUS busy after sound", rd[0], 0);
        check_value("busy length", last_busy_len, 31 * 64 + 1);
        end_test(2, "jump sound");

        period = 16 + ({$random(seed)} % 49);
        wb_write(ADDR_CTRL, 32'h3);
        wb_write(ADDR_PERIOD, period);
        wb_write(ADDR_TRIGGER, 32'h1);
        measure_windows(period, NUM_STAGES);
        check_windows(period, 1'b1, NUM_STAGES);
        @(posedge clk);  // Read samples the first cycle after DONE
        wb_read(ADDR_STATUS, rd);
        check_value("STATUS busy after sound", rd[0], 0);
        check_value("busy length", last_busy_len, 31 * period + 1);
        end_test(3, $sformatf("land sound, period %0d", period));

        wb_write(ADDR_CTRL, 32'h1);
        wb_write(ADDR_PERIOD, 32'd64);
        wb_write(ADDR_TRIGGER, 32'h1);
        measure_windows(64, 10);
        check_windows(64, 1'b0, 10);
        wb_write(ADDR_TRIGGER, 32'h1);  // Lands in stage 10
        fork
            measure_windows(64, 1);
            wb_read(ADDR_STATUS, rd);
        join
        check_windows(64, 1'b0, 1);
        check_value("STATUS busy after retrigger", rd[0], 1);
        check_value("STATUS stage after retrigger", rd[12:8], 0);
        wait_idle(rd);
        end_test(4, "retrigger");

        wb_write(ADDR_TRIGGER, 32'h1);
        measure_windows(64, 3);
        check_windows(64, 1'b0, 3);
        wb_write(ADDR_CTRL, 32'h0);
        check_value("wave_out before disable", wave_out, 1);  // Early in stage 3
        @(posedge clk);
        #1;
        check_value("wave_out after disable", wave_out, 0);
        check_value("busy after disable", sound_unit_top_i.ctrl_if.busy, 0);
        wb_write(ADDR_TRIGGER, 32'h1);
        highs = 0;
        repeat (128) begin
            @(negedge clk);
            if (wave_out) begin
                highs++;
            end
        end
        check_value("wave_out high count while disabled", highs, 0);
        wb_read(ADDR_STATUS, rd);
        check_value("STATUS while disabled", rd, 0);
        end_test(5, "disable");

        $display("summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
sound_pkg.sv
voice_ctrl_if.sv
sound_regs.sv
sound_player.sv
sound_unit_top.sv
tb_clk_gen.sv
sound_unit_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the sound unit testbench with Verilator
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module sound_unit_tb \
    -Mdir obj_dir -o sound_unit_sim > build.log 2>&1 \
    && ./obj_dir/sound_unit_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
